// File: scope_defines.svh
// shared sizes of the digitizer trigger, pulled in by both packages and the rtl with `include
`ifndef SCOPE_DEFINES_SVH
`define SCOPE_DEFINES_SVH

`define NUM_LANES     4    // interleaved adc phases
`define LANE_SAMPLES  10   // samples per lane per clklvds cycle
`define NUM_SAMPLES   40   // whole sample word per cycle
`define SAMPLE_W      12   // signed adc sample width

`define LANE_IDX_W    2    // enough to index NUM_LANES
`define INFO_W        12   // trigger info word, lane index plus crossing mask

`define ADDR_W        10   // ram write address
`define LEN_W         16   // pre and post lengths in write ticks
`define TOT_W         8    // time-over-threshold count
`define DS_W          5    // downsample exponent
`define MERGE_W       8    // merge count per ram write

`endif

// File: sample_pkg.sv
// types for the incoming sample word and its phase lanes, imported by capture, lane and top logic
`include "scope_defines.svh"

package sample_pkg;

   // one signed adc sample
   typedef logic signed [`SAMPLE_W-1:0] sample_t;

   // index j is the j-th sample of a lane in time order
   typedef sample_t [`LANE_SAMPLES-1:0] lane_samples_t;

   // one flag per lane sample, bit 9 belongs to sample 0
   typedef logic [`LANE_SAMPLES-1:0] lane_mask_t;

endpackage

// File: acq_pkg.sv
// acquisition state, trigger type and trigger info word, imported by the controller side of the design
`include "scope_defines.svh"

package acq_pkg;

   import sample_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_pre,        // filling the pre-trigger part of the ram
      st_arm,        // waiting for the first edge step
      st_fire,       // waiting for the second edge step and tot
      st_ext_wait,   // back-panel trigger qualification
      st_post,       // filling the post-trigger part
      st_done        // event offered on the handshake
   } acq_state_t;

   typedef enum logic [2:0] {
      trig_off      = 3'd0,
      trig_rising   = 3'd1,
      trig_falling  = 3'd2,
      trig_auto     = 3'd3,
      trig_external = 3'd4
   } trig_type_t;

   typedef struct packed {
      logic [`LANE_IDX_W-1:0] lane;   // earliest-crossing phase
      lane_mask_t             mask;   // second-step crossings of that lane
   } edge_view_t;

   typedef struct packed {
      logic [`INFO_W-1:0] high_count; // cycles ext_trig was high at the trigger
   } ext_view_t;

   typedef union packed {
      edge_view_t edge_view;
      ext_view_t  ext_view;
   } trig_info_u;

endpackage

// File: sample_capture.sv
// input register stage, holds the sample word and configuration for one cycle and splits lanes
`include "scope_defines.svh"

module sample_capture
   import sample_pkg::*;
   import acq_pkg::*;
(
   input  logic                                 clklvds,
   input  logic                                 reset,
   input  sample_t [`NUM_SAMPLES-1:0]           samples,
   input  sample_t                              lower_thresh,
   input  sample_t                              upper_thresh,
   input  trig_type_t                           trigger_type,
   input  logic [`TOT_W-1:0]                    tot_threshold,
   input  logic [`LEN_W-1:0]                    pre_length,
   input  logic [`LEN_W-1:0]                    post_length,
   input  logic [`DS_W-1:0]                     downsample,
   input  logic [`MERGE_W-1:0]                  merge_count,
   input  logic                                 ext_trig,
   output lane_samples_t [`NUM_LANES-1:0]       lane_data,
   output sample_t                              lower_q,
   output sample_t                              upper_q,
   output logic                                 rising_q,
   output trig_type_t                           type_q,
   output logic [`TOT_W-1:0]                    tot_q,
   output logic [`LEN_W-1:0]                    pre_q,
   output logic [`LEN_W-1:0]                    post_q,
   output logic [`DS_W-1:0]                     ds_q,
   output logic [`MERGE_W-1:0]                  merge_q,
   output logic                                 ext_q
);

   always_ff @(posedge clklvds) begin
      for (int k = 0; k < `NUM_LANES; k++) begin
         lane_data[k] <= samples[k*`LANE_SAMPLES +: `LANE_SAMPLES]; // samples 10k..10k+9
      end
      lower_q <= lower_thresh;
      upper_q <= upper_thresh;
      tot_q   <= tot_threshold;
      pre_q   <= pre_length;
      post_q  <= post_length;
      ds_q    <= downsample;
      merge_q <= merge_count;
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         type_q   <= trig_off;
         rising_q <= 1'b0;
         ext_q    <= 1'b0;
      end else begin
         type_q   <= trigger_type;
         rising_q <= (trigger_type == trig_rising); // lanes only need the direction
         ext_q    <= ext_trig;
      end
   end

endmodule

// File: edge_lane.sv
// threshold comparator for one phase lane, registers the first-step and second-step crossing masks
`include "scope_defines.svh"

module edge_lane
   import sample_pkg::*;
(
   input  logic          clklvds,
   input  logic          reset,
   input  lane_samples_t lane_in,
   input  sample_t       lower_thresh,
   input  sample_t       upper_thresh,
   input  logic          rising,
   output lane_mask_t    first_mask,
   output lane_mask_t    second_mask
);

   lane_mask_t first_next;
   lane_mask_t second_next;

   always_comb begin
      sample_t s;
      logic    below;
      logic    above;
      first_next  = '0;
      second_next = '0;
      for (int j = 0; j < `LANE_SAMPLES; j++) begin
         s     = lane_in[j];
         below = (s < lower_thresh);
         above = (s > upper_thresh);
         // rising edge starts below lower and ends above upper, falling is the mirror
         first_next[`LANE_SAMPLES-1-j]  = rising ? below : above;
         second_next[`LANE_SAMPLES-1-j] = rising ? above : below;
      end
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         first_mask  <= '0;
         second_mask <= '0;
      end else begin
         first_mask  <= first_next;
         second_mask <= second_next;
      end
   end

endmodule

// File: phase_select.sv
// reduces the four lane masks to hit flags and picks the lane whose second step crossed earliest
`include "scope_defines.svh"

module phase_select
   import sample_pkg::*;
   import acq_pkg::*;
(
   input  lane_mask_t [`NUM_LANES-1:0] first_masks,
   input  lane_mask_t [`NUM_LANES-1:0] second_masks,
   output logic                        first_hit,
   output logic                        second_hit,
   output trig_info_u                  best_info
);

   assign first_hit  = |first_masks;
   assign second_hit = |second_masks;

   // a larger mask means a crossing nearer bit 9, i.e. earlier in the lane
   always_comb begin
      lane_mask_t             best_mask;
      logic [`LANE_IDX_W-1:0] best_lane;
      best_mask = '0;
      best_lane = '0;
      for (int k = 0; k < `NUM_LANES; k++) begin
         if (second_masks[k] > best_mask) begin // strict, so ties keep the lower lane
            best_mask = second_masks[k];
            best_lane = `LANE_IDX_W'(k);
         end
      end
      best_info                = '0;
      best_info.edge_view.lane = best_lane;
      best_info.edge_view.mask = best_mask;
   end

endmodule

// File: write_pacer.sv
// paces ram writes by a power-of-two downsample and a merge count while recording, and steps the address
`include "scope_defines.svh"

module write_pacer (
   input  logic                clklvds,
   input  logic                reset,
   input  logic                recording,
   input  logic [`DS_W-1:0]    downsample,
   input  logic [`MERGE_W-1:0] merge_count,
   output logic                ram_wr,
   output logic [`ADDR_W-1:0]  ram_wr_address,
   output logic                write_tick
);

   localparam int DS_CNT_W = 1 << `DS_W; // holds 2^downsample - 1 for any exponent
   localparam logic [DS_CNT_W-1:0] DS_ONE = 1;

   logic [DS_CNT_W-1:0] ds_cnt;
   logic [`MERGE_W-1:0] merge_cnt;
   logic                ds_tick;
   logic                merge_last;

   assign ds_tick    = (ds_cnt == (DS_ONE << downsample) - DS_ONE);
   assign merge_last = ({1'b0, merge_cnt} + 1'b1 >= {1'b0, merge_count}); // count 0 acts as 1

   assign write_tick = recording && ds_tick && merge_last;
   assign ram_wr     = write_tick;

   always_ff @(posedge clklvds) begin
      if (reset) begin
         ds_cnt         <= '0;
         merge_cnt      <= '0;
         ram_wr_address <= '0;
      end else if (!recording) begin
         ds_cnt    <= '0; // restart pacing, address frozen
         merge_cnt <= '0;
      end else begin
         if (ds_tick) begin
            ds_cnt    <= '0;
            merge_cnt <= merge_last ? '0 : merge_cnt + 1'b1;
         end else begin
            ds_cnt <= ds_cnt + 1'b1;
         end
         if (write_tick) ram_wr_address <= ram_wr_address + 1'b1;
      end
   end

endmodule

// File: acq_controller.sv
// acquisition state machine, runs pre and post counting, the trigger modes and the event handshake
`include "scope_defines.svh"

module acq_controller
   import acq_pkg::*;
(
   input  logic               clklvds,
   input  logic               reset,
   input  logic               arm,
   input  trig_type_t         type_q,
   input  logic [`TOT_W-1:0]  tot_q,
   input  logic [`LEN_W-1:0]  pre_q,
   input  logic [`LEN_W-1:0]  post_q,
   input  logic               ext_q,
   input  logic               first_hit,
   input  logic               second_hit,
   input  trig_info_u         best_info,
   input  logic               write_tick,
   input  logic [`ADDR_W-1:0] ram_wr_address,
   output logic               recording,
   output logic               event_valid,
   input  logic               event_ready,
   output logic [`ADDR_W-1:0] event_address,
   output trig_type_t         event_type,
   output trig_info_u         event_info
);

   acq_state_t          state;
   trig_type_t          type_act;   // type latched when leaving idle
   logic [`LEN_W-1:0]   len_cnt;    // pre or post write ticks
   logic [`LEN_W:0]     len_inc;
   logic [`TOT_W-1:0]   tot_cnt;
   logic                info_seen;
   trig_info_u          info_lat;   // edge info of the first second-step cycle
   logic                ext_prev;
   logic                ext_seen;
   logic                ext_armed;
   logic                type_changed;
   logic                armed;
   logic                pre_done;
   logic                post_done;
   logic                fire_now;
   trig_info_u          info_now;

   assign recording    = (state != st_idle) && (state != st_done);
   assign event_valid  = (state == st_done);
   assign type_changed = (type_q != type_act);
   assign armed        = (state == st_pre) || (state == st_arm) ||
                         (state == st_fire) || (state == st_ext_wait);
   assign len_inc      = {1'b0, len_cnt} + 1'b1;
   assign pre_done     = (len_cnt >= pre_q);
   assign post_done    = count_done(len_cnt, len_inc, post_q, write_tick);
   assign ext_armed    = ext_seen || (ext_q && !ext_prev);

   // post ends on the cycle of its last write tick, so no extra ram_wr slips in
   function automatic logic count_done(input logic [`LEN_W-1:0] cnt,
                                       input logic [`LEN_W:0]   inc,
                                       input logic [`LEN_W-1:0] len,
                                       input logic              tick);
      return (cnt >= len) || (tick && (inc >= {1'b0, len}));
   endfunction

   always_comb begin
      fire_now = 1'b0;
      info_now = '0;
      case (state)
         st_pre: fire_now = pre_done && (type_act == trig_auto); // auto fires at once
         st_fire: begin
            fire_now = second_hit && (tot_cnt >= tot_q);
            info_now = info_seen ? info_lat : best_info;
         end
         st_ext_wait: begin
            fire_now = ext_armed && ext_q && (tot_cnt >= tot_q);
            info_now.ext_view.high_count = `INFO_W'(tot_cnt) + 1'b1;
         end
         default: ;
      endcase
      if (type_changed) fire_now = 1'b0;
   end

   always_ff @(posedge clklvds) begin
      if (reset) begin
         state     <= st_idle;
         type_act  <= trig_off;
         len_cnt   <= '0;
         tot_cnt   <= '0;
         info_seen <= 1'b0;
         ext_seen  <= 1'b0;
         ext_prev  <= 1'b0;
      end else begin
         ext_prev <= ext_q;
         if (armed && type_changed) begin
            state <= st_idle;
         end else if (fire_now) begin
            state   <= st_post;
            len_cnt <= '0;
         end else begin
            case (state)
               st_idle: begin
                  type_act  <= type_q;
                  len_cnt   <= '0;
                  tot_cnt   <= '0;
                  info_seen <= 1'b0;
                  ext_seen  <= 1'b0;
                  if (arm && type_q != trig_off) state <= st_pre;
               end
               st_pre: begin
                  if (!pre_done) begin
                     if (write_tick) len_cnt <= len_inc[`LEN_W-1:0];
                  end else if (type_act == trig_external) begin
                     state <= st_ext_wait;
                  end else begin
                     state <= st_arm; // rising or falling
                  end
               end
               st_arm: if (first_hit) state <= st_fire;
               st_fire: begin
                  if (second_hit) info_seen <= 1'b1;
                  if (second_hit && write_tick) tot_cnt <= tot_cnt + 1'b1;
               end
               st_ext_wait: begin
                  if (ext_q && !ext_prev) ext_seen <= 1'b1;
                  if (ext_armed && ext_q) tot_cnt <= tot_cnt + 1'b1;
                  else tot_cnt <= '0; // pulse ended, qualify again from zero
               end
               st_post: begin
                  if (post_done) state <= st_done;
                  else if (write_tick) len_cnt <= len_inc[`LEN_W-1:0];
               end
               st_done: if (event_ready) state <= st_idle;
               default: state <= st_idle;
            endcase
         end
      end
   end

   always_ff @(posedge clklvds) begin
      if (state == st_fire && second_hit && !info_seen) info_lat <= best_info;
      if (fire_now) begin
         event_address <= ram_wr_address - `ADDR_W'(tot_q); // back up by the tot wait
         event_type    <= type_act;
         event_info    <= info_now;
      end
   end

endmodule

// File: scope_trigger_top.sv
// top of the digitizer trigger, connects capture, lane comparators, phase select, pacer and controller
`include "scope_defines.svh"

module scope_trigger_top
   import sample_pkg::*;
   import acq_pkg::*;
(
   input  logic                       clklvds,
   input  logic                       reset,
   input  sample_t [`NUM_SAMPLES-1:0] samples,
   input  sample_t                    lower_thresh,
   input  sample_t                    upper_thresh,
   input  trig_type_t                 trigger_type,
   input  logic [`TOT_W-1:0]          tot_threshold,
   input  logic [`LEN_W-1:0]          pre_length,
   input  logic [`LEN_W-1:0]          post_length,
   input  logic [`DS_W-1:0]           downsample,
   input  logic [`MERGE_W-1:0]        merge_count,
   input  logic                       arm,
   input  logic                       ext_trig,
   input  logic                       event_ready,
   output logic                       ram_wr,
   output logic [`ADDR_W-1:0]         ram_wr_address,
   output logic                       event_valid,
   output logic [`ADDR_W-1:0]         event_address,
   output trig_type_t                 event_type,
   output trig_info_u                 event_info
);

   lane_samples_t [`NUM_LANES-1:0] lane_data;
   lane_mask_t [`NUM_LANES-1:0]    first_masks;
   lane_mask_t [`NUM_LANES-1:0]    second_masks;
   sample_t                        lower_q;
   sample_t                        upper_q;
   logic                           rising_q;
   trig_type_t                     type_q;
   logic [`TOT_W-1:0]              tot_q;
   logic [`LEN_W-1:0]              pre_q;
   logic [`LEN_W-1:0]              post_q;
   logic [`DS_W-1:0]               ds_q;
   logic [`MERGE_W-1:0]            merge_q;
   logic                           ext_q;
   logic                           first_hit;
   logic                           second_hit;
   trig_info_u                     best_info;
   logic                           recording;
   logic                           write_tick;

   sample_capture u_capture (
      .clklvds(clklvds), .reset(reset), .samples(samples),
      .lower_thresh(lower_thresh), .upper_thresh(upper_thresh), .trigger_type(trigger_type),
      .tot_threshold(tot_threshold), .pre_length(pre_length), .post_length(post_length),
      .downsample(downsample), .merge_count(merge_count), .ext_trig(ext_trig),
      .lane_data(lane_data), .lower_q(lower_q), .upper_q(upper_q), .rising_q(rising_q),
      .type_q(type_q), .tot_q(tot_q), .pre_q(pre_q), .post_q(post_q), .ds_q(ds_q),
      .merge_q(merge_q), .ext_q(ext_q)
   );

   for (genvar k = 0; k < `NUM_LANES; k++) begin : g_lane
      edge_lane u_lane (
         .clklvds(clklvds), .reset(reset), .lane_in(lane_data[k]),
         .lower_thresh(lower_q), .upper_thresh(upper_q), .rising(rising_q),
         .first_mask(first_masks[k]), .second_mask(second_masks[k])
      );
   end

   phase_select u_phase (
      .first_masks(first_masks), .second_masks(second_masks),
      .first_hit(first_hit), .second_hit(second_hit), .best_info(best_info)
   );

   write_pacer u_pacer (
      .clklvds(clklvds), .reset(reset), .recording(recording), .downsample(ds_q),
      .merge_count(merge_q), .ram_wr(ram_wr), .ram_wr_address(ram_wr_address),
      .write_tick(write_tick)
   );

   acq_controller u_ctrl (
      .clklvds(clklvds), .reset(reset), .arm(arm), .type_q(type_q), .tot_q(tot_q),
      .pre_q(pre_q), .post_q(post_q), .ext_q(ext_q), .first_hit(first_hit),
      .second_hit(second_hit), .best_info(best_info), .write_tick(write_tick),
      .ram_wr_address(ram_wr_address), .recording(recording), .event_valid(event_valid),
      .event_ready(event_ready), .event_address(event_address), .event_type(event_type),
      .event_info(event_info)
   );

endmodule

// File: tb_scope_trigger.sv
// self-checking testbench for the digitizer trigger top, runs auto, edge and external events
`include "scope_defines.svh"

module tb_scope_trigger
   import sample_pkg::*;
   import acq_pkg::*;
();

   localparam int RESET_CYCLES  = 16;
   localparam int TEST_OVERHEAD = 60;          // configure, plants, hold and handshake per test
   localparam int EXT_CYCLES    = 3 + 15 + 12; // short pulse, quiet wait, long pulse
   // pre plus post write ticks of each test times its write period
   localparam int RUN_CYCLES = RESET_CYCLES + (8 + 10) * 6 + (6 + 12) * 2 + (5 + 7) * 4
                               + (4 + 9) * 1 + 4 * TEST_OVERHEAD + EXT_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES + 200;

   logic                       clklvds;
   logic                       reset;
   sample_t [`NUM_SAMPLES-1:0] samples;
   sample_t                    lower_thresh;
   sample_t                    upper_thresh;
   trig_type_t                 trigger_type;
   logic [`TOT_W-1:0]          tot_threshold;
   logic [`LEN_W-1:0]          pre_length;
   logic [`LEN_W-1:0]          post_length;
   logic [`DS_W-1:0]           downsample;
   logic [`MERGE_W-1:0]        merge_count;
   logic                       arm;
   logic                       ext_trig;
   logic                       event_ready;
   logic                       ram_wr;
   logic [`ADDR_W-1:0]         ram_wr_address;
   logic                       event_valid;
   logic [`ADDR_W-1:0]         event_address;
   trig_type_t                 event_type;
   trig_info_u                 event_info;

   logic [31:0]        rng;
   int                 mismatches;
   int                 failures;
   int                 cycles;
   int                 pulse_total;  // ram_wr pulses since reset
   logic [`ADDR_W-1:0] wr_count;     // own model of the write address
   int                 prev_cycle;
   logic               have_prev;
   int                 exp_period;
   logic               acq_active;   // from arm until the handshake
   string              test_name;

   scope_trigger_top dut (.*);

   always #4 clklvds = ~clklvds;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // background stays within -400..399 inside the thresholds
   function automatic sample_t background_sample();
      rng = xorshift32(rng);
      return sample_t'(int'(rng % 32'd800) - 400);
   endfunction

   task automatic next_cycle();
      @(negedge clklvds);
      for (int i = 0; i < `NUM_SAMPLES; i++) begin
         samples[i] = background_sample();
      end
   endtask

   task automatic check_equal(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected === actual) else begin
         mismatches++;
         $display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      end
   endtask

   task automatic configure(input string name, input trig_type_t tt, input int ds, input int m,
                            input int pre, input int post, input int tot);
      next_cycle();
      test_name     = name;
      trigger_type  = tt;
      downsample    = `DS_W'(ds);
      merge_count   = `MERGE_W'(m);
      pre_length    = `LEN_W'(pre);
      post_length   = `LEN_W'(post);
      tot_threshold = `TOT_W'(tot);
      exp_period    = (1 << ds) * m;
      repeat (3) next_cycle(); // let the capture stage settle
   endtask

   task automatic arm_event();
      next_cycle();
      arm        = 1'b1;
      acq_active = 1'b1;
      next_cycle();
      arm = 1'b0;
   endtask

   task automatic wait_pulses(input int base, input int n);
      while (pulse_total - base < n) next_cycle();
   endtask

   task automatic wait_event();
      while (!event_valid) next_cycle();
   endtask

   // back-pressure first, then a single ready cycle
   task automatic accept_event(input int hold);
      repeat (hold) next_cycle();
      event_ready = 1'b1;
      next_cycle();
      event_ready = 1'b0;
      assert (!event_valid) else begin
         failures++;
         $display("%s: event_valid still high after the ready cycle", test_name);
      end
      acq_active = 1'b0;
   endtask

   task automatic run_auto(input int ds, input int m, input int pre, input int post);
      int                 base;
      logic [`ADDR_W-1:0] addr0;
      configure("auto", trig_auto, ds, m, pre, post, 0);
      base  = pulse_total;
      addr0 = wr_count;
      arm_event();
      wait_event();
      // write period above one, so the trigger cycle carries no write
      check_equal("post writes", 32'(post), 32'(pulse_total - base - pre));
      check_equal("type", 32'(trig_auto), 32'(event_type));
      check_equal("address", 32'(`ADDR_W'(addr0 + pre)), 32'(event_address));
      accept_event(20);
   endtask

   task automatic run_edge(input string name, input logic rise, input int lane, input int pos,
                           input int ds, input int m, input int pre, input int post);
      int                 base;
      logic [11:0]        exp_info;
      logic [`ADDR_W-1:0] exp_addr;
      sample_t            first_val;
      sample_t            second_val;
      first_val  = rise ? sample_t'(-900) : sample_t'(900);
      second_val = rise ? sample_t'(900) : sample_t'(-900);
      configure(name, rise ? trig_rising : trig_falling, ds, m, pre, post, 0);
      base = pulse_total;
      arm_event();
      wait_pulses(base, pre);
      repeat (4) next_cycle();  // pre hands over to arm
      next_cycle();
      samples[5] = first_val;
      repeat (4) next_cycle();
      samples[lane * `LANE_SAMPLES + pos] = second_val;
      repeat (2) next_cycle();  // capture and lane register
      exp_addr = wr_count;      // address seen in the trigger cycle
      wait_event();
      exp_info = {lane[1:0], 10'b0};
      exp_info[9 - pos] = 1'b1;
      check_equal("type", 32'(rise ? trig_rising : trig_falling), 32'(event_type));
      check_equal("lane and mask", 32'(exp_info), 32'(event_info));
      check_equal("address", 32'(exp_addr), 32'(event_address));
      accept_event(12);
   endtask

   task automatic run_external(input int pre, input int post, input int tot);
      int base;
      configure("external", trig_external, 0, 1, pre, post, tot);
      base = pulse_total;
      arm_event();
      wait_pulses(base, pre);
      repeat (4) next_cycle();
      ext_trig = 1'b1;
      repeat (tot / 2) next_cycle(); // too short to qualify
      ext_trig = 1'b0;
      repeat (15) begin
         next_cycle();
         assert (!event_valid) else begin
            failures++;
            $display("%s: event raised by a pulse shorter than the threshold", test_name);
         end
      end
      ext_trig = 1'b1;
      repeat (tot * 2) next_cycle();
      ext_trig = 1'b0;
      wait_event();
      check_equal("type", 32'(trig_external), 32'(event_type));
      check_equal("high count", 32'(tot + 1), 32'(event_info));
      accept_event(10);
   endtask

   always @(posedge clklvds) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // write pacing and own address model
   always @(posedge clklvds) begin
      if (!reset && ram_wr) begin
         if (have_prev) begin
            assert (cycles - prev_cycle == exp_period) else begin
               mismatches++;
               $display("Mismatch %s write period: expected %0d, actual %0d",
                        test_name, exp_period, cycles - prev_cycle);
            end
         end
         have_prev   <= 1'b1;
         prev_cycle  <= cycles;
         pulse_total <= pulse_total + 1;
         wr_count    <= wr_count + 1'b1;
      end
      if (event_valid || !acq_active) have_prev <= 1'b0; // pacing restarts per event
   end

   assert property (@(posedge clklvds) disable iff (reset) event_valid |-> !ram_wr)
      else begin
         failures++;
         $display("ram_wr pulsed while an event was waiting on the handshake");
      end

   assert property (@(posedge clklvds) disable iff (reset) !acq_active |-> !ram_wr)
      else begin
         failures++;
         $display("ram_wr pulsed while no acquisition was running");
      end

   assert property (@(posedge clklvds) disable iff (reset)
                    ram_wr |=> (ram_wr_address == $past(ram_wr_address) + 1'b1))
      else begin
         failures++;
         $display("ram_wr_address did not step by one after a write");
      end

   // address moves only with ram_wr, so it must track the pulse count
   assert property (@(posedge clklvds) disable iff (reset) ram_wr_address == wr_count)
      else begin
         mismatches++;
         $display("Mismatch %s write address: expected %0h, actual %0h",
                  test_name, $sampled(wr_count), $sampled(ram_wr_address));
      end

   assert property (@(posedge clklvds) disable iff (reset)
                    (event_valid && !event_ready) |=> (event_valid && $stable(event_address)
                    && $stable(event_type) && $stable(event_info)))
      else begin
         failures++;
         $display("event_valid or an event field changed before event_ready");
      end

   assert property (@(posedge clklvds) disable iff (reset)
                    (event_valid && event_ready) |=> !event_valid)
      else begin
         failures++;
         $display("event_valid did not drop after the accepting cycle");
      end

   initial begin
      clklvds       = 1'b0;
      reset         = 1'b1;
      rng           = 32'h79fb;
      samples       = '0;
      lower_thresh  = -12'sd500;
      upper_thresh  = 12'sd500;
      trigger_type  = trig_off;
      tot_threshold = '0;
      pre_length    = '0;
      post_length   = '0;
      downsample    = '0;
      merge_count   = 8'd1;
      arm           = 1'b0;
      ext_trig      = 1'b0;
      event_ready   = 1'b0;
      mismatches    = 0;
      failures      = 0;
      cycles        = 0;
      pulse_total   = 0;
      wr_count      = '0;
      prev_cycle    = 0;
      have_prev     = 1'b0;
      exp_period    = 1;
      acq_active    = 1'b0;
      test_name     = "reset";
      repeat (RESET_CYCLES) @(negedge clklvds);
      reset = 1'b0;
      run_auto(1, 3, 8, 10);
      run_edge("rising", 1'b1, 2, 6, 0, 2, 6, 12);
      run_edge("falling", 1'b0, 1, 0, 2, 1, 5, 7);
      run_external(4, 9, 6);
      repeat (4) next_cycle();
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: compile.f
+incdir+.
sample_pkg.sv
acq_pkg.sv
sample_capture.sv
edge_lane.sv
phase_select.sv
write_pacer.sv
acq_controller.sv
scope_trigger_top.sv
tb_scope_trigger.sv

// File: Bender.yml
package:
  name: scope_trigger

export_include_dirs:
  - .

sources:
  - sample_pkg.sv
  - acq_pkg.sv
  - sample_capture.sv
  - edge_lane.sv
  - phase_select.sv
  - write_pacer.sv
  - acq_controller.sv
  - scope_trigger_top.sv
  - target: test
    files:
      - tb_scope_trigger.sv
